/* project.f */
wb_mem_pkg.sv
wb_req_queue.sv
wb_mem_engine.sv
wb_resp_stage.sv
wb_pipe_mem_top.sv
wb_pipe_mem_props.sv
tb_wb_pipe_mem.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run from the project root, nonzero exit on failure
verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_pipe_mem -f project.f -o tb_wb_pipe_mem \
    && ./obj_dir/tb_wb_pipe_mem \
    || { echo "simulation did not pass"; exit 1; }

/* tb_wb_pipe_mem.sv */
`timescale 1ns/1ps

module tb_wb_pipe_mem
    import wb_mem_pkg::*;
;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    RAND_SEED    = 26;
    localparam int    MAX_REQ      = 64;
    localparam int    BURST_LEN    = 10;    // leading requests sent back to back
    localparam int    QUIET_CYCLES = 20;
    localparam string STIM_FILE    = "wb_mem_stim.txt";

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              cyc_i;
    logic              stb_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [SEL_W-1:0]  sel_i;
    logic [DATA_W-1:0] wdata_i;
    logic [DATA_W-1:0] rdata_o;
    logic              ack_o;
    logic              err_o;
    logic              stall_o;

    // requests and expected responses from the data file
    logic              req_we    [MAX_REQ];
    logic [ADDR_W-1:0] req_addr  [MAX_REQ];
    logic [SEL_W-1:0]  req_sel   [MAX_REQ];
    logic [DATA_W-1:0] req_wdata [MAX_REQ];
    logic [DATA_W-1:0] req_rdata [MAX_REQ];
    logic              req_err   [MAX_REQ];
    int                n_req = 0;

    int   exp_q [$];        // accepted request indices, oldest first
    int   cycle_cnt = 0;    // cycles since reset release
    logic saw_full = 1'b0;

    wb_pipe_mem_top wb_pipe_mem_top_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ack_o   (ack_o),
        .err_o   (err_o),
        .stall_o (stall_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic check_val(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic load_stimulus();
        int                fd;
        int                n_fields;
        string             line;
        logic [7:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] rdata;
        logic              err;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("the stimulus file could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                op = line.getc(0);
                if (line.len() > 1 && op != "/") begin   // skip comments and blank lines
                    n_fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                       addr, sel, wdata, rdata, err);
                    if (n_fields != 5 || (op != "W" && op != "R")) begin
                        abort_run($sformatf("malformed stimulus line: %s", line));
                    end else if (n_req == MAX_REQ) begin
                        abort_run("the stimulus file holds too many requests");
                    end else begin
                        req_we[n_req]    = (op == "W");
                        req_addr[n_req]  = addr;
                        req_sel[n_req]   = sel;
                        req_wdata[n_req] = wdata;
                        req_rdata[n_req] = rdata;
                        req_err[n_req]   = err;
                        n_req++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // present one request and hold it until an edge with stall_o low
    task automatic drive_request(input int idx);
        logic taken;
        taken = 1'b0;
        cyc_i   <= 1'b1;
        stb_i   <= 1'b1;
        we_i    <= req_we[idx];
        addr_i  <= req_addr[idx];
        sel_i   <= req_sel[idx];
        wdata_i <= req_wdata[idx];
        while (!taken) begin
            @(negedge clk_i);
            taken = !stall_o;
            if (taken) begin
                check_val(DATA_W'(cycle_cnt >= INIT_STALL_CYCLES), DATA_W'(1),
                          $sformatf("request %0d accepted during start-up stall", idx));
                exp_q.push_back(idx);
            end
            @(posedge clk_i);
        end
    endtask

    task automatic drive_all();
        int gap;
        for (int i = 0; i < n_req; i++) begin
            drive_request(i);
            gap = (i < BURST_LEN) ? 0 : int'($urandom % 4);
            if (gap > 0) begin
                stb_i <= 1'b0;
                repeat (gap) @(posedge clk_i);
            end
        end
        stb_i <= 1'b0;
        cyc_i <= 1'b0;
    endtask

    task automatic collect_responses();
        int idx;
        int n_resp;
        n_resp = 0;
        while (n_resp < n_req) begin
            @(negedge clk_i);
            if (stall_o && cycle_cnt >= INIT_STALL_CYCLES) begin
                saw_full = 1'b1;    // start-up over, so this is the near-full stall
            end
            if (ack_o || err_o) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("a response arrived at %0t ns with no request open",
                                        $time));
                end else begin
                    idx = exp_q.pop_front();
                    check_val(DATA_W'(err_o), DATA_W'(req_err[idx]),
                              $sformatf("err_o of request %0d", idx));
                    check_val(DATA_W'(ack_o), DATA_W'(!req_err[idx]),
                              $sformatf("ack_o of request %0d", idx));
                    check_val(rdata_o, req_rdata[idx], $sformatf("rdata_o of request %0d", idx));
                    n_resp++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_n_i = 1'b0;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        sel_i   = '0;
        wdata_i = '0;
        load_stimulus();
        if (n_req == 0) begin
            abort_run("the stimulus file holds no requests");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk_i);
            rst_n_i <= 1'b1;
            fork
                drive_all();
                collect_responses();
            join
            // nothing more may come back
            repeat (QUIET_CYCLES) begin
                @(negedge clk_i);
                check_val(DATA_W'(ack_o || err_o), DATA_W'(0), "response without a request");
            end
            check_val(DATA_W'(saw_full), DATA_W'(1), "stall_o never rose for a full queue");
            $display("TB PASSED");
            $finish;
        end
    end

    // watchdog, limit scales with the request count
    initial begin
        longint limit_ns;
        wait (n_req > 0);
        limit_ns = longint'(n_req) * (SWITCH_DELAY + QUEUE_DEPTH * SWITCH_DELAY + 10) * CLK_PERIOD
                 + longint'(RESET_CYCLES + INIT_STALL_CYCLES + QUIET_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout, the responses did not all arrive within %0d ns", limit_ns);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* wb_mem_engine.sv */
`timescale 1ns/1ps

module wb_mem_engine
    import wb_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    // head of the request queue
    input  logic              valid_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              pop_o,

    // service result, one pulse per request
    output logic              done_o,
    output logic              err_o,
    output logic [DATA_W-1:0] rdata_o
);

    // word array, no reset
    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic             last_we;   // direction of the last served request
    logic             armed;     // counter loaded for current head
    logic [DLY_W-1:0] dly_cnt;

    logic              fire;
    logic              in_range;
    logic              wr_en;
    logic              same_dir;
    logic [MEM_AW-1:0] mem_idx;

    assign in_range = (32'(addr_i) < 32'(MEM_WORDS));
    assign mem_idx  = addr_i[MEM_AW-1:0];
    assign same_dir = (we_i == last_we);

    // served once the wait for this head has run out
    assign fire  = armed && (dly_cnt == '0);
    assign wr_en = fire && we_i && in_range;

    assign pop_o  = fire;
    assign done_o = fire;
    assign err_o  = fire && !in_range;

    // asynchronous read, zero when nothing is read
    assign rdata_o = (fire && !we_i && in_range) ? mem[mem_idx] : '0;

    // delay counter and direction tracking
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_we <= 1'b0;         // start as if the last access was a read
            armed   <= 1'b0;
            dly_cnt <= '0;
        end else begin
            if (fire) begin
                armed   <= 1'b0;     // next head gets a fresh load
                last_we <= we_i;     // error requests count too
            end else if (armed) begin
                dly_cnt <= dly_cnt - DLY_W'(1);
            end else if (valid_i) begin
                armed   <= 1'b1;
                dly_cnt <= same_dir ? DLY_W'(SAME_DELAY) : DLY_W'(SWITCH_DELAY);
            end
        end
    end

    // byte-lane write from the queued data
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (sel_i[i]) begin
                    mem[mem_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* wb_mem_pkg.sv */
package wb_mem_pkg;

    // bus geometry
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;     // one lane per byte
    localparam int ADDR_W = 12;             // word address

    // implemented storage, addresses at or above MEM_WORDS are errors
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // request queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // start-up stall, in clock cycles
    localparam int INIT_STALL_CYCLES = 16;
    localparam int STALL_CNT_W       = $clog2(INIT_STALL_CYCLES + 1);

    // service wait, in clock cycles
    localparam int SAME_DELAY   = 2;        // direction unchanged
    localparam int SWITCH_DELAY = 5;        // read to write or back
    localparam int MAX_DELAY    = (SWITCH_DELAY > SAME_DELAY) ? SWITCH_DELAY : SAME_DELAY;
    localparam int DLY_W        = $clog2(MAX_DELAY + 1);

endpackage

/* wb_mem_stim.txt */
// columns: op addr sel wdata exp_rdata exp_err, all hex, one request per line
// op W writes and R reads, exp_rdata is zero for writes and for errors
W 000 F 11223344 00000000 0
W 001 F 55667788 00000000 0
W 002 F 99AABBCC 00000000 0
W 003 F DDEEFF00 00000000 0
W 004 F 01234567 00000000 0
W 005 F 89ABCDEF 00000000 0
W 3FF F CAFEF00D 00000000 0
W 200 F 0BADBEEF 00000000 0
W 0FF F A5A55A5A 00000000 0
W 010 F 13579BDF 00000000 0
R 000 F 00000000 11223344 0
R 001 F 00000000 55667788 0
R 3FF F 00000000 CAFEF00D 0
W 002 1 000000EE 00000000 0
W 002 4 00770000 00000000 0
R 002 F 00000000 9977BBEE 0
W 003 C 12340000 00000000 0
R 003 F 00000000 1234FF00 0
W 004 3 0000ABCD 00000000 0
W 004 8 FF000000 00000000 0
R 004 F 00000000 FF23ABCD 0
W 005 0 FFFFFFFF 00000000 0
R 005 F 00000000 89ABCDEF 0
W 005 A 11223344 00000000 0
R 005 F 00000000 11AB33EF 0
W 400 F DEADDEAD 00000000 1
R 400 F 00000000 00000000 1
R 000 F 00000000 11223344 0
W 7FF F 12345678 00000000 1
R 3FF F 00000000 CAFEF00D 0
R FFF F 00000000 00000000 1
W 100 F 76543210 00000000 0
R 100 F 00000000 76543210 0
W 100 5 00AA00BB 00000000 0
R 100 F 00000000 76AA32BB 0
R 200 F 00000000 0BADBEEF 0
W 200 2 0000CC00 00000000 0
R 200 F 00000000 0BADCCEF 0
R 0FF F 00000000 A5A55A5A 0
W 0FF F 5A5AA5A5 00000000 0
R 0FF F 00000000 5A5AA5A5 0
R 010 F 00000000 13579BDF 0
W 3FF 1 00000011 00000000 0
R 3FF F 00000000 CAFEF011 0
R 002 F 00000000 9977BBEE 0

/* wb_pipe_mem_props.sv */
`timescale 1ns/1ps

module wb_pipe_mem_props
    import wb_mem_pkg::*;
(
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              ack_i,
    input logic              err_i,
    input logic              stall_i,
    input logic [DATA_W-1:0] rdata_i
);

    logic [STALL_CNT_W-1:0] since_rst;   // saturates at INIT_STALL_CYCLES

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            since_rst <= '0;
        end else if (since_rst != STALL_CNT_W'(INIT_STALL_CYCLES)) begin
            since_rst <= since_rst + STALL_CNT_W'(1);
        end
    end

    ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ack_i && err_i))
        else $error("ack_o and err_o high in the same cycle");

    startup_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (since_rst < STALL_CNT_W'(INIT_STALL_CYCLES)) |-> stall_i)
        else $error("stall_o low during the start-up period");

    // nothing can be served while the queue is still closed
    startup_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (since_rst < STALL_CNT_W'(INIT_STALL_CYCLES)) |-> !(ack_i || err_i))
        else $error("response during the start-up period");

    rdata_idle_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ack_i |-> (rdata_i == '0))
        else $error("rdata_o nonzero without ack_o");

endmodule

bind wb_pipe_mem_top wb_pipe_mem_props wb_pipe_mem_props_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ack_i   (ack_o),
    .err_i   (err_o),
    .stall_i (stall_o),
    .rdata_i (rdata_o)
);

/* wb_pipe_mem_top.sv */
`timescale 1ns/1ps

module wb_pipe_mem_top
    import wb_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,

    output logic [DATA_W-1:0] rdata_o,
    output logic              ack_o,
    output logic              err_o,
    output logic              stall_o
);

    // queue head
    logic              q_valid;
    logic              q_we;
    logic [ADDR_W-1:0] q_addr;
    logic [SEL_W-1:0]  q_sel;
    logic [DATA_W-1:0] q_wdata;
    logic              q_pop;

    // service result
    logic              svc_done;
    logic              svc_err;
    logic [DATA_W-1:0] svc_rdata;

    wb_req_queue wb_req_queue_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .stall_o (stall_o),
        .pop_i   (q_pop),
        .valid_o (q_valid),
        .we_o    (q_we),
        .addr_o  (q_addr),
        .sel_o   (q_sel),
        .wdata_o (q_wdata)
    );

    wb_mem_engine wb_mem_engine_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (q_valid),
        .we_i    (q_we),
        .addr_i  (q_addr),
        .sel_i   (q_sel),
        .wdata_i (q_wdata),
        .pop_o   (q_pop),
        .done_o  (svc_done),
        .err_o   (svc_err),
        .rdata_o (svc_rdata)
    );

    wb_resp_stage wb_resp_stage_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .done_i  (svc_done),
        .err_i   (svc_err),
        .rdata_i (svc_rdata),
        .ack_o   (ack_o),
        .err_o   (err_o),
        .rdata_o (rdata_o)
    );

endmodule

/* wb_req_queue.sv */
`timescale 1ns/1ps

module wb_req_queue
    import wb_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    // wishbone request side
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              stall_o,

    // head of queue towards the engine
    input  logic              pop_i,
    output logic              valid_o,
    output logic              we_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic [SEL_W-1:0]  sel_o,
    output logic [DATA_W-1:0] wdata_o
);

    // entry storage, one array per field
    logic              we_q    [QUEUE_DEPTH];
    logic [ADDR_W-1:0] addr_q  [QUEUE_DEPTH];
    logic [SEL_W-1:0]  sel_q   [QUEUE_DEPTH];
    logic [DATA_W-1:0] wdata_q [QUEUE_DEPTH];

    logic [QPTR_W-1:0]      wr_ptr;
    logic [QPTR_W-1:0]      rd_ptr;
    logic [QCNT_W-1:0]      count;
    logic [STALL_CNT_W-1:0] init_cnt;

    logic push;
    logic pop;
    logic near_full;

    assign near_full = (count >= QCNT_W'(QUEUE_DEPTH - 1)); // one slot spare for the registered count
    assign stall_o   = (init_cnt != '0) || near_full;

    assign push = cyc_i && stb_i && !stall_o;
    assign pop  = pop_i && (count != '0);

    // start-up stall counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            init_cnt <= STALL_CNT_W'(INIT_STALL_CYCLES);
        end else if (init_cnt != '0) begin
            init_cnt <= init_cnt - STALL_CNT_W'(1);
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + QPTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + QPTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + QCNT_W'(1);
                2'b01:   count <= count - QCNT_W'(1);
                default: count <= count;   // idle, or push and pop together
            endcase
        end
    end

    // capture request fields, write data included
    always_ff @(posedge clk_i) begin
        if (push) begin
            we_q[wr_ptr]    <= we_i;
            addr_q[wr_ptr]  <= addr_i;
            sel_q[wr_ptr]   <= sel_i;
            wdata_q[wr_ptr] <= wdata_i;
        end
    end

    assign valid_o = (count != '0);
    assign we_o    = we_q[rd_ptr];
    assign addr_o  = addr_q[rd_ptr];
    assign sel_o   = sel_q[rd_ptr];
    assign wdata_o = wdata_q[rd_ptr];

endmodule

/* wb_resp_stage.sv */
`timescale 1ns/1ps

module wb_resp_stage
    import wb_mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    // from the service engine
    input  logic              done_i,
    input  logic              err_i,
    input  logic [DATA_W-1:0] rdata_i,

    // wishbone response
    output logic              ack_o,
    output logic              err_o,
    output logic [DATA_W-1:0] rdata_o
);

    logic ok;

    assign ok = done_i && !err_i;   // ack and err never together

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            ack_o   <= ok;
            err_o   <= done_i && err_i;
            rdata_o <= ok ? rdata_i : '0;   // bus data only alongside ack
        end
    end

endmodule
